// File: verilog/mesh_noc_pkg.sv
`default_nettype none

package mesh_noc_pkg;

  // Router ports, P is the local endpoint
  localparam int NOC_DIR_W = 3;

  typedef enum logic [NOC_DIR_W-1:0] {
    P = 0,
    W,
    E,
    N,
    S
  } noc_dir_e;

  localparam int NOC_PORTS = 5;             // Local plus four links
  localparam int NOC_LINKS = 4;             // W, E, N, S

  // 4x4 mesh
  localparam int X_CORD_W = 2;
  localparam int Y_CORD_W = 2;

  localparam int NOC_ADDR_W = 6;            // Word address
  localparam int NOC_DATA_W = 32;
  localparam int NOC_OP_W   = 2;

  // Packet layout, opcode on top and data at the bottom
  localparam int PKT_DATA_LSB  = 0;
  localparam int PKT_ADDR_LSB  = PKT_DATA_LSB + NOC_DATA_W;
  localparam int PKT_SRC_Y_LSB = PKT_ADDR_LSB + NOC_ADDR_W;
  localparam int PKT_SRC_X_LSB = PKT_SRC_Y_LSB + Y_CORD_W;
  localparam int PKT_DST_Y_LSB = PKT_SRC_X_LSB + X_CORD_W;
  localparam int PKT_DST_X_LSB = PKT_DST_Y_LSB + Y_CORD_W;
  localparam int PKT_OP_LSB    = PKT_DST_X_LSB + X_CORD_W;
  localparam int NOC_PKT_W     = PKT_OP_LSB + NOC_OP_W;  // 48 bits

  localparam int NOC_FIFO_DEPTH = 4;        // Entries per input queue

endpackage

`default_nettype wire

// File: verilog/tile_mem_pkg.sv
`default_nettype none

package tile_mem_pkg;

  // Opcodes carried in the packet opcode field
  typedef enum logic [mesh_noc_pkg::NOC_OP_W-1:0] {
    MEM_STORE,
    MEM_LOAD,
    MEM_LOAD_RSP,
    MEM_NOP
  } mem_op_e;

  localparam int MEM_WORDS  = 64;
  localparam int MEM_ADDR_W = $clog2(MEM_WORDS);  // Word index bits

endpackage

`default_nettype wire

// File: verilog/link_input_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module link_input_fifo #(
  parameter int depth_p = mesh_noc_pkg::NOC_FIFO_DEPTH
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               push_i,
  input  logic [mesh_noc_pkg::NOC_PKT_W-1:0] pkt_i,
  input  logic                               pop_i,
  output logic                               head_valid_o,
  output logic [mesh_noc_pkg::NOC_PKT_W-1:0] head_pkt_o,
  output logic                               overflow_o
);

  import mesh_noc_pkg::*;

  localparam int ptr_w_lp = $clog2(depth_p);
  localparam int cnt_w_lp = $clog2(depth_p + 1);

  logic [NOC_PKT_W-1:0] mem_q [depth_p];
  logic [ptr_w_lp-1:0]  wr_ptr_q;
  logic [ptr_w_lp-1:0]  rd_ptr_q;
  logic [cnt_w_lp-1:0]  count_q;
  logic                 full;
  logic                 do_push;
  logic                 do_pop;

  assign full         = (count_q == cnt_w_lp'(depth_p));
  assign head_valid_o = (count_q != '0);
  assign head_pkt_o   = mem_q[rd_ptr_q];
  assign do_push      = push_i && !full;       // Full queue drops the packet
  assign do_pop       = pop_i && head_valid_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= pkt_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (do_push) begin
        // Wrap for any depth, not only powers of two
        wr_ptr_q <= (wr_ptr_q == ptr_w_lp'(depth_p - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w_lp'(depth_p - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
      if (push_i && full) begin
        overflow_o <= 1'b1;                    // Sticky until reset
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/xy_route_switch.sv
`default_nettype none
`timescale 1ns/1ps

module xy_route_switch (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic [mesh_noc_pkg::X_CORD_W-1:0]  my_x_i,
  input  logic [mesh_noc_pkg::Y_CORD_W-1:0]  my_y_i,
  input  logic                               head_valid_i [mesh_noc_pkg::NOC_PORTS],
  input  logic [mesh_noc_pkg::NOC_PKT_W-1:0] head_pkt_i   [mesh_noc_pkg::NOC_PORTS],
  output logic                               pop_o        [mesh_noc_pkg::NOC_PORTS],
  output logic                               out_valid_o  [mesh_noc_pkg::NOC_PORTS],
  output logic [mesh_noc_pkg::NOC_PKT_W-1:0] out_pkt_o    [mesh_noc_pkg::NOC_PORTS]
);

  import mesh_noc_pkg::*;

  logic [X_CORD_W-1:0] dst_x     [NOC_PORTS];
  logic [Y_CORD_W-1:0] dst_y     [NOC_PORTS];
  noc_dir_e            route_dir [NOC_PORTS];   // Wanted output per input
  logic                req       [NOC_PORTS][NOC_PORTS];  // [output][input]
  logic                gnt_valid [NOC_PORTS];
  noc_dir_e            gnt_idx   [NOC_PORTS];   // Granted input per output
  noc_dir_e            rr_q      [NOC_PORTS];   // Last granted input per output

  // X first, then Y
  always_comb begin
    for (int i = 0; i < NOC_PORTS; i++) begin
      dst_x[i] = head_pkt_i[i][PKT_DST_X_LSB +: X_CORD_W];
      dst_y[i] = head_pkt_i[i][PKT_DST_Y_LSB +: Y_CORD_W];
      if (dst_x[i] > my_x_i) begin
        route_dir[i] = E;
      end else if (dst_x[i] < my_x_i) begin
        route_dir[i] = W;
      end else if (dst_y[i] > my_y_i) begin
        route_dir[i] = S;
      end else if (dst_y[i] < my_y_i) begin
        route_dir[i] = N;
      end else begin
        route_dir[i] = P;
      end
    end
  end

  // An input asks for exactly one output, so one grant per input at most
  always_comb begin
    for (int o = 0; o < NOC_PORTS; o++) begin
      for (int i = 0; i < NOC_PORTS; i++) begin
        req[o][i] = head_valid_i[i] && (route_dir[i] == noc_dir_e'(o));
      end
    end
  end

  // Round robin, search starts just after the last winner
  always_comb begin
    int cand;
    cand = 0;
    for (int o = 0; o < NOC_PORTS; o++) begin
      gnt_valid[o] = 1'b0;
      gnt_idx[o]   = rr_q[o];
      for (int k = 1; k <= NOC_PORTS; k++) begin
        cand = int'(rr_q[o]) + k;
        if (cand >= NOC_PORTS) begin
          cand = cand - NOC_PORTS;
        end
        if (!gnt_valid[o] && req[o][cand]) begin
          gnt_valid[o] = 1'b1;
          gnt_idx[o]   = noc_dir_e'(cand);
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NOC_PORTS; i++) begin
      pop_o[i] = 1'b0;
    end
    for (int o = 0; o < NOC_PORTS; o++) begin
      if (gnt_valid[o]) begin
        pop_o[gnt_idx[o]] = 1'b1;              // Queue moves on at the same edge
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int o = 0; o < NOC_PORTS; o++) begin
        out_valid_o[o] <= 1'b0;
        rr_q[o]        <= S;                   // P gets first pick after reset
      end
    end else begin
      for (int o = 0; o < NOC_PORTS; o++) begin
        out_valid_o[o] <= gnt_valid[o];
        if (gnt_valid[o]) begin
          rr_q[o] <= gnt_idx[o];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NOC_PORTS; o++) begin
      if (gnt_valid[o]) begin
        out_pkt_o[o] <= head_pkt_i[gnt_idx[o]];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/mesh_router.sv
`default_nettype none
`timescale 1ns/1ps

module mesh_router (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic [mesh_noc_pkg::X_CORD_W-1:0]  my_x_i,
  input  logic [mesh_noc_pkg::Y_CORD_W-1:0]  my_y_i,
  input  logic                               in_valid_i  [mesh_noc_pkg::NOC_PORTS],
  input  logic [mesh_noc_pkg::NOC_PKT_W-1:0] in_pkt_i    [mesh_noc_pkg::NOC_PORTS],
  output logic                               out_valid_o [mesh_noc_pkg::NOC_PORTS],
  output logic [mesh_noc_pkg::NOC_PKT_W-1:0] out_pkt_o   [mesh_noc_pkg::NOC_PORTS],
  output logic                               overflow_o
);

  import mesh_noc_pkg::*;

  logic                 head_valid [NOC_PORTS];
  logic [NOC_PKT_W-1:0] head_pkt   [NOC_PORTS];
  logic                 pop        [NOC_PORTS];
  logic                 q_overflow [NOC_PORTS];

  // One queue per input port, indexed by noc_dir_e
  for (genvar p = 0; p < NOC_PORTS; p++) begin : g_in_q
    link_input_fifo #(
      .depth_p (NOC_FIFO_DEPTH)
    ) link_input_fifo_inst (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .push_i       (in_valid_i[p]),
      .pkt_i        (in_pkt_i[p]),
      .pop_i        (pop[p]),
      .head_valid_o (head_valid[p]),
      .head_pkt_o   (head_pkt[p]),
      .overflow_o   (q_overflow[p])
    );
  end

  xy_route_switch xy_route_switch_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .my_x_i       (my_x_i),
    .my_y_i       (my_y_i),
    .head_valid_i (head_valid),
    .head_pkt_i   (head_pkt),
    .pop_o        (pop),
    .out_valid_o  (out_valid_o),
    .out_pkt_o    (out_pkt_o)
  );

  // Each flag is sticky, so the OR is too
  always_comb begin
    overflow_o = 1'b0;
    for (int p = 0; p < NOC_PORTS; p++) begin
      overflow_o = overflow_o | q_overflow[p];
    end
  end

endmodule

`default_nettype wire

// File: verilog/tile_mem_endpoint.sv
`default_nettype none
`timescale 1ns/1ps

module tile_mem_endpoint (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic [mesh_noc_pkg::X_CORD_W-1:0]  my_x_i,
  input  logic [mesh_noc_pkg::Y_CORD_W-1:0]  my_y_i,
  input  logic                               req_valid_i,
  input  logic [mesh_noc_pkg::NOC_PKT_W-1:0] req_pkt_i,
  output logic                               rsp_valid_o,
  output logic [mesh_noc_pkg::NOC_PKT_W-1:0] rsp_pkt_o
);

  import mesh_noc_pkg::*;
  import tile_mem_pkg::*;

  mem_op_e               req_op;
  logic [X_CORD_W-1:0]   req_src_x;
  logic [Y_CORD_W-1:0]   req_src_y;
  logic [NOC_ADDR_W-1:0] req_addr;
  logic [NOC_DATA_W-1:0] req_data;
  logic [MEM_ADDR_W-1:0] mem_idx;
  logic [NOC_DATA_W-1:0] mem_q [MEM_WORDS];
  logic [NOC_PKT_W-1:0]  rsp_next;

  // Request fields
  assign req_op    = mem_op_e'(req_pkt_i[PKT_OP_LSB +: NOC_OP_W]);
  assign req_src_x = req_pkt_i[PKT_SRC_X_LSB +: X_CORD_W];
  assign req_src_y = req_pkt_i[PKT_SRC_Y_LSB +: Y_CORD_W];
  assign req_addr  = req_pkt_i[PKT_ADDR_LSB +: NOC_ADDR_W];
  assign req_data  = req_pkt_i[PKT_DATA_LSB +: NOC_DATA_W];
  assign mem_idx   = req_addr[MEM_ADDR_W-1:0];

  // Response goes back to whoever asked
  always_comb begin
    rsp_next = '0;
    rsp_next[PKT_OP_LSB    +: NOC_OP_W]   = MEM_LOAD_RSP;
    rsp_next[PKT_DST_X_LSB +: X_CORD_W]   = req_src_x;
    rsp_next[PKT_DST_Y_LSB +: Y_CORD_W]   = req_src_y;
    rsp_next[PKT_SRC_X_LSB +: X_CORD_W]   = my_x_i;
    rsp_next[PKT_SRC_Y_LSB +: Y_CORD_W]   = my_y_i;
    rsp_next[PKT_ADDR_LSB  +: NOC_ADDR_W] = req_addr;  // Echo address
    rsp_next[PKT_DATA_LSB  +: NOC_DATA_W] = mem_q[mem_idx];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;                        // Unwritten words read as zero
      end
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= 1'b0;
      if (req_valid_i) begin
        case (req_op)
          MEM_STORE: mem_q[mem_idx] <= req_data;
          MEM_LOAD:  rsp_valid_o    <= 1'b1;
          default:   ;                         // Responses and NOPs are dropped here
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && (req_op == MEM_LOAD)) begin
      rsp_pkt_o <= rsp_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/mesh_tile.sv
`default_nettype none
`timescale 1ns/1ps

module mesh_tile (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic [mesh_noc_pkg::X_CORD_W-1:0]  my_x_i,
  input  logic [mesh_noc_pkg::Y_CORD_W-1:0]  my_y_i,
  // Indexed by noc_dir_e, W through S
  input  logic                               link_valid_i [1:mesh_noc_pkg::NOC_LINKS],
  input  logic [mesh_noc_pkg::NOC_PKT_W-1:0] link_pkt_i   [1:mesh_noc_pkg::NOC_LINKS],
  output logic                               link_valid_o [1:mesh_noc_pkg::NOC_LINKS],
  output logic [mesh_noc_pkg::NOC_PKT_W-1:0] link_pkt_o   [1:mesh_noc_pkg::NOC_LINKS],
  output logic                               overflow_o
);

  import mesh_noc_pkg::*;

  logic [1:0]           rst_sync_q;
  logic                 rst_sync_n;
  logic                 rtr_in_valid  [NOC_PORTS];
  logic [NOC_PKT_W-1:0] rtr_in_pkt    [NOC_PORTS];
  logic                 rtr_out_valid [NOC_PORTS];
  logic [NOC_PKT_W-1:0] rtr_out_pkt   [NOC_PORTS];
  logic                 ep_valid;
  logic [NOC_PKT_W-1:0] ep_pkt;

  // Assert at once, release after two clocks
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_sync_n = rst_sync_q[1];

  assign rtr_in_valid[P] = ep_valid;           // Endpoint feeds the local queue
  assign rtr_in_pkt[P]   = ep_pkt;

  for (genvar d = W; d <= S; d++) begin : g_link
    assign rtr_in_valid[d] = link_valid_i[d];
    assign rtr_in_pkt[d]   = link_pkt_i[d];
    assign link_valid_o[d] = rtr_out_valid[d];
    assign link_pkt_o[d]   = rtr_out_pkt[d];
  end

  mesh_router mesh_router_inst (
    .clk_i       (clk_i),
    .arst_n_i    (rst_sync_n),
    .my_x_i      (my_x_i),
    .my_y_i      (my_y_i),
    .in_valid_i  (rtr_in_valid),
    .in_pkt_i    (rtr_in_pkt),
    .out_valid_o (rtr_out_valid),
    .out_pkt_o   (rtr_out_pkt),
    .overflow_o  (overflow_o)
  );

  tile_mem_endpoint tile_mem_endpoint_inst (
    .clk_i       (clk_i),
    .arst_n_i    (rst_sync_n),
    .my_x_i      (my_x_i),
    .my_y_i      (my_y_i),
    .req_valid_i (rtr_out_valid[P]),
    .req_pkt_i   (rtr_out_pkt[P]),
    .rsp_valid_o (ep_valid),
    .rsp_pkt_o   (ep_pkt)
  );

endmodule

`default_nettype wire

// File: verif/mesh_tile_tb.sv
`default_nettype none
`timescale 1ns/1ps

module mesh_tile_tb;

  import mesh_noc_pkg::*;
  import tile_mem_pkg::*;

  localparam int clk_period_lp = 40;
  localparam logic [X_CORD_W-1:0] tile_x_lp = 2'd1;
  localparam logic [Y_CORD_W-1:0] tile_y_lp = 2'd2;
  localparam int gap_lp = 4;                     // Idle cycles after each strobe
  localparam int tag_w_lp = NOC_DIR_W + NOC_PKT_W;

  typedef struct packed {
    noc_dir_e             in_dir;
    logic                 same_cycle;            // Next row shares this cycle
    logic [NOC_PKT_W-1:0] pkt;
    logic                 exp_none;              // Consumed inside the tile
    noc_dir_e             exp_dir;
    logic [NOC_PKT_W-1:0] exp_pkt;
  } stim_t;

  logic                 clk_i;
  logic                 arst_n_i;
  logic                 link_valid_i [1:NOC_LINKS];
  logic [NOC_PKT_W-1:0] link_pkt_i   [1:NOC_LINKS];
  logic                 link_valid_o [1:NOC_LINKS];
  logic [NOC_PKT_W-1:0] link_pkt_o   [1:NOC_LINKS];
  logic                 overflow_o;

  stim_t                stim_q[$];
  logic [tag_w_lp-1:0]  pending_q[$];            // {direction, packet} still owed
  logic [NOC_DATA_W-1:0] mem_model [MEM_WORDS];
  logic                 table_ready;
  logic                 mon_en;
  logic                 flood_en;
  int                   err_value;
  int                   err_missing;
  int                   err_other;

  mesh_tile mesh_tile_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .my_x_i       (tile_x_lp),
    .my_y_i       (tile_y_lp),
    .link_valid_i (link_valid_i),
    .link_pkt_i   (link_pkt_i),
    .link_valid_o (link_valid_o),
    .link_pkt_o   (link_pkt_o),
    .overflow_o   (overflow_o)
  );

  always #(clk_period_lp / 2) clk_i = ~clk_i;

  // X first, then Y, as seen from tile (1,2)
  function automatic noc_dir_e route_of(input logic [X_CORD_W-1:0] dx,
                                        input logic [Y_CORD_W-1:0] dy);
    if (dx > tile_x_lp) return E;
    if (dx < tile_x_lp) return W;
    if (dy > tile_y_lp) return S;
    if (dy < tile_y_lp) return N;
    return P;
  endfunction

  task automatic add_row(input noc_dir_e in_dir, input mem_op_e op,
                         input logic [X_CORD_W-1:0] dx, input logic [Y_CORD_W-1:0] dy,
                         input logic [X_CORD_W-1:0] sx, input logic [Y_CORD_W-1:0] sy,
                         input logic [NOC_ADDR_W-1:0] addr, input logic same_cycle);
    stim_t                 row;
    logic [NOC_DATA_W-1:0] data;
    data           = $urandom;
    row.in_dir     = in_dir;
    row.same_cycle = same_cycle;
    row.pkt        = {op, dx, dy, sx, sy, addr, data};
    row.exp_none   = 1'b0;
    row.exp_dir    = route_of(dx, dy);
    row.exp_pkt    = row.pkt;                    // Forwarded packets leave unchanged
    if (row.exp_dir == P) begin
      row.exp_none = 1'b1;
      if (op == MEM_STORE) begin
        mem_model[addr] = data;
      end else if (op == MEM_LOAD) begin
        row.exp_none = 1'b0;
        row.exp_dir  = route_of(sx, sy);         // Response heads back to the source
        row.exp_pkt  = {MEM_LOAD_RSP, sx, sy, tile_x_lp, tile_y_lp, addr, mem_model[addr]};
      end
    end
    stim_q.push_back(row);
  endtask

  task automatic release_links();
    for (int d = 1; d <= NOC_LINKS; d++) begin
      link_valid_i[d] <= 1'b0;
    end
  endtask

  // Either arrival order is fine, so search rather than pop the front
  task automatic match_output(input noc_dir_e dir, input logic [NOC_PKT_W-1:0] pkt);
    logic [tag_w_lp-1:0] entry;
    int                  hit;
    int                  first;
    hit   = -1;
    first = -1;
    for (int i = 0; i < pending_q.size(); i++) begin
      entry = pending_q[i];
      if (entry[tag_w_lp-1 -: NOC_DIR_W] == dir) begin
        if (first < 0) first = i;
        if (hit < 0 && entry[NOC_PKT_W-1:0] == pkt) hit = i;
      end
    end
    if (hit >= 0) begin
      pending_q.delete(hit);
    end else if (first >= 0) begin
      entry = pending_q[first];
      $display("FAIL %0t link_pkt_o[%s] expected %h got %h", $time, dir.name(),
               entry[NOC_PKT_W-1:0], pkt);
      err_value++;
      pending_q.delete(first);
    end else begin
      $display("Unexpected packet %h left on link %s at %0t", pkt, dir.name(), $time);
      err_other++;
    end
  endtask

  task automatic check_overflow(input logic expected);
    @(negedge clk_i);
    if (overflow_o !== expected) begin
      $display("FAIL %0t overflow_o expected %b got %b", $time, expected, overflow_o);
      err_value++;
    end
  endtask

  always @(negedge clk_i) begin
    if (mon_en && !flood_en) begin
      for (int d = 1; d <= NOC_LINKS; d++) begin
        if (link_valid_o[d] === 1'b1) begin
          match_output(noc_dir_e'(d), link_pkt_o[d]);
        end
      end
    end
  end

  initial begin
    wait (table_ready);
    repeat (stim_q.size() * 20 + 200) @(posedge clk_i);
    $display("Watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    stim_t               row;
    logic [tag_w_lp-1:0] entry;
    noc_dir_e            dir;
    int                  idx;
    int                  waited;
    void'($urandom(27939));
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    mon_en      = 1'b0;
    flood_en    = 1'b0;
    table_ready = 1'b0;
    err_value   = 0;
    err_missing = 0;
    err_other   = 0;
    for (int d = 1; d <= NOC_LINKS; d++) begin
      link_valid_i[d] = 1'b0;
      link_pkt_i[d]   = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = '0;
    end

    // Through traffic, X differs
    add_row(W, MEM_STORE,    2'd3, 2'd0, 2'd0, 2'd2, 6'd1, 1'b0);
    add_row(E, MEM_LOAD,     2'd0, 2'd3, 2'd2, 2'd2, 6'd2, 1'b0);
    add_row(N, MEM_NOP,      2'd2, 2'd2, 2'd1, 2'd0, 6'd3, 1'b0);
    add_row(S, MEM_LOAD_RSP, 2'd0, 2'd1, 2'd1, 2'd3, 6'd4, 1'b0);
    add_row(W, MEM_STORE,    2'd0, 2'd0, 2'd2, 2'd1, 6'd5, 1'b0);  // U-turn
    // Through traffic, same column
    add_row(W, MEM_LOAD,     2'd1, 2'd0, 2'd0, 2'd2, 6'd6, 1'b0);
    add_row(E, MEM_STORE,    2'd1, 2'd3, 2'd3, 2'd2, 6'd7, 1'b0);
    add_row(N, MEM_NOP,      2'd1, 2'd3, 2'd1, 2'd0, 6'd8, 1'b0);
    add_row(S, MEM_LOAD,     2'd1, 2'd1, 2'd1, 2'd3, 6'd9, 1'b0);
    // Local memory
    add_row(W, MEM_STORE,    2'd1, 2'd2, 2'd0, 2'd2, 6'd5, 1'b0);
    add_row(E, MEM_LOAD,     2'd1, 2'd2, 2'd0, 2'd2, 6'd5, 1'b0);
    add_row(N, MEM_LOAD,     2'd1, 2'd2, 2'd0, 2'd2, 6'd12, 1'b0); // Never stored
    add_row(S, MEM_STORE,    2'd1, 2'd2, 2'd3, 2'd1, 6'd12, 1'b0);
    add_row(N, MEM_LOAD,     2'd1, 2'd2, 2'd3, 2'd1, 6'd12, 1'b0);
    add_row(W, MEM_NOP,      2'd1, 2'd2, 2'd0, 2'd2, 6'd20, 1'b0);
    add_row(E, MEM_LOAD_RSP, 2'd1, 2'd2, 2'd0, 2'd2, 6'd21, 1'b0);
    // Two links, one output, same cycle
    add_row(W, MEM_NOP,      2'd3, 2'd1, 2'd0, 2'd1, 6'd30, 1'b1);
    add_row(N, MEM_STORE,    2'd2, 2'd0, 2'd1, 2'd0, 6'd31, 1'b0);
    add_row(E, MEM_LOAD,     2'd1, 2'd0, 2'd2, 2'd2, 6'd32, 1'b1);
    add_row(S, MEM_NOP,      2'd1, 2'd1, 2'd1, 2'd3, 6'd33, 1'b0);
    table_ready = 1'b1;

    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;
    repeat (4) @(posedge clk_i);                 // Local reset release
    mon_en = 1'b1;
    repeat (10) @(posedge clk_i);                // Idle, monitor flags any strobe
    check_overflow(1'b0);

    idx = 0;
    while (idx < stim_q.size()) begin
      @(posedge clk_i);
      do begin
        row = stim_q[idx];
        link_valid_i[row.in_dir] <= 1'b1;
        link_pkt_i[row.in_dir]   <= row.pkt;
        if (!row.exp_none) begin
          pending_q.push_back({row.exp_dir, row.exp_pkt});
        end
        idx++;
      end while (row.same_cycle && idx < stim_q.size());
      @(posedge clk_i);
      release_links();
      repeat (gap_lp) @(posedge clk_i);
    end

    waited = 0;
    while (pending_q.size() != 0 && waited < 100) begin
      @(posedge clk_i);
      waited++;
    end
    for (int i = 0; i < pending_q.size(); i++) begin
      entry = pending_q[i];
      dir   = noc_dir_e'(entry[tag_w_lp-1 -: NOC_DIR_W]);
      $display("Packet %h never came out on link %s", entry[NOC_PKT_W-1:0], dir.name());
      err_missing++;
    end
    pending_q.delete();
    check_overflow(1'b0);

    // All four links toward E, far more than the queues hold
    flood_en = 1'b1;
    for (int c = 0; c < 8; c++) begin
      @(posedge clk_i);
      for (int d = 1; d <= NOC_LINKS; d++) begin
        link_valid_i[d] <= 1'b1;
        link_pkt_i[d]   <= {MEM_NOP, 2'd3, 2'(d - 1), tile_x_lp, tile_y_lp, 6'(c),
                            32'($urandom)};
      end
    end
    @(posedge clk_i);
    release_links();
    check_overflow(1'b1);
    repeat (20) @(posedge clk_i);
    check_overflow(1'b1);                        // Sticky

    $display("Errors: %0d wrong value, %0d missing, %0d other",
             err_value, err_missing, err_other);
    if (err_value + err_missing + err_other == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
verilog/mesh_noc_pkg.sv
verilog/tile_mem_pkg.sv
verilog/link_input_fifo.sv
verilog/xy_route_switch.sv
verilog/mesh_router.sv
verilog/tile_mem_endpoint.sv
verilog/mesh_tile.sv
verif/mesh_tile_tb.sv

// File: Bender.yml
package:
  name: mesh_tile

dependencies: {}

sources:
  # RTL in compile order
  - files:
      - verilog/mesh_noc_pkg.sv
      - verilog/tile_mem_pkg.sv
      - verilog/link_input_fifo.sv
      - verilog/xy_route_switch.sv
      - verilog/mesh_router.sv
      - verilog/tile_mem_endpoint.sv
      - verilog/mesh_tile.sv

  # Testbench
  - target: simulation
    files:
      - verif/mesh_tile_tb.sv
